// ==== hdl/rx_pkg.sv ====
// package with widths, beat field typedefs, L2 destination prefixes and the write FSM state

package rx_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int N_CH       = 4;   // default number of linear channels
    localparam int ADDR_W     = 16;  // L2 byte address below the prefix
    localparam int LEN_W      = 16;
    localparam int FIFO_DEPTH = 4;   // default depth of the beat buffer

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [31:0]       data_t;
    typedef logic [3:0]        be_t;
    typedef logic [1:0]        dsize_t;   // 0 byte, 1 halfword, 2 word
    typedef logic [1:0]        dest_t;
    typedef logic [1:0]        nbytes_t;  // bytes in the beat minus one

    //////////////////////////////////////////////////////////////////////
    // destination prefixes, placed in the top bits of the L2 address
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0]  DEST0_PREFIX = 8'h1C;   // also used by code 3
    localparam logic [11:0] DEST1_PREFIX = 12'h1A1;
    localparam logic [7:0]  DEST2_PREFIX = 8'h10;

    // a split beat spends one cycle per grant in each state
    typedef enum logic {
        WR_IDLE,
        WR_SECOND
    } wr_state_t;

endpackage

// ==== hdl/rx_channel_addr.sv ====
// channel address generator with current address, remaining length, enable and end event
`timescale 1ns/1ps

module rx_channel_addr (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  rx_pkg::addr_t   cfg_startaddr_i,
    input  rx_pkg::len_t    cfg_len_i,
    input  logic            cfg_en_i,
    input  logic            take_i,
    input  rx_pkg::dsize_t  dsize_i,
    output rx_pkg::addr_t   curr_addr_o,
    output rx_pkg::nbytes_t nbytes_o,
    output logic            en_o,
    output logic            event_o
);
    import rx_pkg::*;

    addr_t addr_q;
    len_t  remain_q;
    len_t  size_bytes;
    len_t  take_len;
    logic  en_q;
    logic  event_q;
    logic  last;

    always_comb
    begin
        case (dsize_i)
            2'd1:    size_bytes = len_t'(2);
            2'd2:    size_bytes = len_t'(4);
            default: size_bytes = len_t'(1);  // byte, and the unused code 3
        endcase
    end

    // the final beat only carries what is left of the transfer
    assign take_len = (remain_q < size_bytes) ? remain_q : size_bytes;
    assign last     = (remain_q == take_len);

    assign curr_addr_o = addr_q;
    assign nbytes_o    = nbytes_t'(take_len - len_t'(1));
    assign en_o        = en_q;
    assign event_o     = event_q;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            addr_q   <= '0;
            remain_q <= '0;
            en_q     <= 1'b0;
            event_q  <= 1'b0;
        end
        else
        begin
            event_q <= 1'b0;
            if (cfg_en_i)
            begin
                addr_q   <= cfg_startaddr_i;
                remain_q <= cfg_len_i;
                en_q     <= (cfg_len_i != '0);  // an empty transfer never starts
            end
            else if (take_i)
            begin
                addr_q   <= addr_q + addr_t'(take_len);
                remain_q <= remain_q - take_len;
                if (last)
                begin
                    en_q    <= 1'b0;
                    event_q <= 1'b1;  // one cycle, on the edge of the last beat
                end
            end
        end
    end

    // the arbiter in the input stage only grants enabled channels
    assert property (@(posedge clk_i) disable iff (!rstn_i) take_i |-> en_q);

endmodule

// ==== hdl/rx_input_stage.sv ====
// input stage with round-robin arbiter, per-channel address generators and sample register
`timescale 1ns/1ps

module rx_input_stage #(
    parameter int N_CH = rx_pkg::N_CH
) (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic            [N_CH-1:0]         ch_valid_i,
    input  rx_pkg::data_t   [N_CH-1:0]         ch_data_i,
    input  rx_pkg::dsize_t  [N_CH-1:0]         ch_dsize_i,
    input  rx_pkg::dest_t   [N_CH-1:0]         ch_dest_i,
    output logic            [N_CH-1:0]         ch_ready_o,
    input  rx_pkg::addr_t   [N_CH-1:0]         cfg_startaddr_i,
    input  rx_pkg::len_t    [N_CH-1:0]         cfg_len_i,
    input  logic            [N_CH-1:0]         cfg_en_i,
    output logic            [N_CH-1:0]         ch_en_o,
    output logic            [N_CH-1:0]         ch_event_o,
    input  logic                               space_i,
    output logic                               push_o,
    output rx_pkg::data_t                      beat_data_o,
    output rx_pkg::addr_t                      beat_addr_o,
    output rx_pkg::dsize_t                     beat_dsize_o,
    output rx_pkg::nbytes_t                    beat_nbytes_o,
    output rx_pkg::dest_t                      beat_dest_o
);
    import rx_pkg::*;

    localparam int PTR_W = (N_CH > 1) ? $clog2(N_CH) : 1;

    logic    [N_CH-1:0]  req;
    logic    [N_CH-1:0]  grant;
    logic    [N_CH-1:0]  take;
    logic    [PTR_W-1:0] grant_idx;
    logic    [PTR_W-1:0] rr_ptr_q;
    logic                any_grant;
    logic                advance;
    addr_t   [N_CH-1:0]  ch_addr;
    nbytes_t [N_CH-1:0]  ch_nbytes;

    logic    smp_valid_q;
    data_t   smp_data_q;
    addr_t   smp_addr_q;
    dsize_t  smp_dsize_q;
    nbytes_t smp_nbytes_q;
    dest_t   smp_dest_q;

    //////////////////////////////////////////////////////////////////////
    // channel address generators
    //////////////////////////////////////////////////////////////////////

    for (genvar j = 0; j < N_CH; j++)
    begin : g_ch
        rx_channel_addr u_ch_addr (
            .clk_i           ( clk_i              ),
            .rstn_i          ( rstn_i             ),
            .cfg_startaddr_i ( cfg_startaddr_i[j] ),
            .cfg_len_i       ( cfg_len_i[j]       ),
            .cfg_en_i        ( cfg_en_i[j]        ),
            .take_i          ( take[j]            ),
            .dsize_i         ( ch_dsize_i[j]      ),
            .curr_addr_o     ( ch_addr[j]         ),
            .nbytes_o        ( ch_nbytes[j]       ),
            .en_o            ( ch_en_o[j]         ),
            .event_o         ( ch_event_o[j]      )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // round-robin arbiter
    //////////////////////////////////////////////////////////////////////

    assign req = ch_valid_i & ch_en_o;

    // search starts at the pointer and wraps around the channels
    always_comb
    begin : rr_pick
        int unsigned idx;
        grant     = '0;
        grant_idx = '0;
        any_grant = 1'b0;
        for (int k = 0; k < N_CH; k++)
        begin
            idx = (int'(rr_ptr_q) + k) % N_CH;
            if (!any_grant && req[idx])
            begin
                any_grant  = 1'b1;
                grant[idx] = 1'b1;
                grant_idx  = PTR_W'(idx);
            end
        end
    end

    assign advance    = !smp_valid_q || space_i;    // sample register can take a new beat
    assign ch_ready_o = grant & {N_CH{advance}};
    assign take       = ch_valid_i & ch_ready_o;

    //////////////////////////////////////////////////////////////////////
    // sample register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            smp_valid_q <= 1'b0;
            rr_ptr_q    <= '0;
        end
        else if (advance)
        begin
            smp_valid_q <= any_grant;
            if (any_grant)
                rr_ptr_q <= (grant_idx == PTR_W'(N_CH - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (advance && any_grant)
        begin
            smp_data_q   <= ch_data_i[grant_idx];
            smp_dsize_q  <= ch_dsize_i[grant_idx];
            smp_dest_q   <= ch_dest_i[grant_idx];
            smp_addr_q   <= ch_addr[grant_idx];    // address before this beat advances it
            smp_nbytes_q <= ch_nbytes[grant_idx];
        end
    end

    assign push_o        = smp_valid_q && space_i;
    assign beat_data_o   = smp_data_q;
    assign beat_addr_o   = smp_addr_q;
    assign beat_dsize_o  = smp_dsize_q;
    assign beat_nbytes_o = smp_nbytes_q;
    assign beat_dest_o   = smp_dest_q;

    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(ch_ready_o));

endmodule

// ==== hdl/rx_beat_fifo.sv ====
// circular buffer of sampled beats between the input stage and the L2 write port
`timescale 1ns/1ps

module rx_beat_fifo #(
    parameter int FIFO_DEPTH = rx_pkg::FIFO_DEPTH
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            push_i,
    input  rx_pkg::data_t   data_i,
    input  rx_pkg::addr_t   addr_i,
    input  rx_pkg::dsize_t  dsize_i,
    input  rx_pkg::nbytes_t nbytes_i,
    input  rx_pkg::dest_t   dest_i,
    output logic            space_o,
    output logic            not_empty_o,
    output rx_pkg::data_t   data_o,
    output rx_pkg::addr_t   addr_o,
    output rx_pkg::dsize_t  dsize_o,
    output rx_pkg::nbytes_t nbytes_o,
    output rx_pkg::dest_t   dest_o,
    input  logic            pop_i
);
    import rx_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    data_t   mem_data   [FIFO_DEPTH];
    addr_t   mem_addr   [FIFO_DEPTH];
    dsize_t  mem_dsize  [FIFO_DEPTH];
    nbytes_t mem_nbytes [FIFO_DEPTH];
    dest_t   mem_dest   [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign space_o     = (count_q != CNT_W'(FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);

    assign data_o   = mem_data[rd_ptr_q];
    assign addr_o   = mem_addr[rd_ptr_q];
    assign dsize_o  = mem_dsize[rd_ptr_q];
    assign nbytes_o = mem_nbytes[rd_ptr_q];
    assign dest_o   = mem_dest[rd_ptr_q];

    always_ff @(posedge clk_i)
    begin
        if (push_i)
        begin
            mem_data[wr_ptr_q]   <= data_i;
            mem_addr[wr_ptr_q]   <= addr_i;
            mem_dsize[wr_ptr_q]  <= dsize_i;
            mem_nbytes[wr_ptr_q] <= nbytes_i;
            mem_dest[wr_ptr_q]   <= dest_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop_i)
                rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither keep the level
            endcase
        end
    end

    // the input stage holds its beat while the buffer is full
    assert property (@(posedge clk_i) disable iff (!rstn_i) push_i |-> space_o);

    // the write port only retires a beat that is present
    assert property (@(posedge clk_i) disable iff (!rstn_i) pop_i |-> not_empty_o);

endmodule

// ==== hdl/l2_write_port.sv ====
// L2 write port with address prefix, byte enables, lane shift and split of non-aligned beats
`timescale 1ns/1ps

module l2_write_port (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            not_empty_i,
    input  rx_pkg::data_t   data_i,
    input  rx_pkg::addr_t   addr_i,
    input  rx_pkg::dsize_t  dsize_i,
    input  rx_pkg::nbytes_t nbytes_i,
    input  rx_pkg::dest_t   dest_i,
    output logic            pop_o,
    output logic            l2_req_o,
    input  logic            l2_gnt_i,
    output logic [31:0]     l2_addr_o,
    output rx_pkg::be_t     l2_be_o,
    output rx_pkg::data_t   l2_wdata_o
);
    import rx_pkg::*;

    wr_state_t         state_q;
    wr_state_t         state_d;
    logic              second;
    logic [1:0]        offset;
    logic [2:0]        lane_end;    // offset plus byte count minus one
    logic              is_split;
    be_t               lane_mask;
    logic [7:0]        be_span;
    data_t             data_trim;
    logic [63:0]       data_span;
    logic [ADDR_W-3:0] word_addr;
    nbytes_t           size_nbytes;

    assign second   = (state_q == WR_SECOND);
    assign offset   = addr_i[1:0];
    assign lane_end = {1'b0, offset} + {1'b0, nbytes_i};
    assign is_split = lane_end[2];  // the beat runs past lane 3

    //////////////////////////////////////////////////////////////////////
    // lanes and data over two words
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (nbytes_i)
            2'd0:    lane_mask = 4'b0001;
            2'd1:    lane_mask = 4'b0011;
            2'd2:    lane_mask = 4'b0111;
            default: lane_mask = 4'b1111;
        endcase
    end

    // bytes beyond the beat's count go out as zero
    always_comb
    begin
        for (int b = 0; b < 4; b++)
            data_trim[8*b +: 8] = lane_mask[b] ? data_i[8*b +: 8] : 8'h00;
    end

    // the upper half of the span is the leftover for the following word
    assign be_span   = {4'h0, lane_mask} << offset;
    assign data_span = {32'h0, data_trim} << {offset, 3'b000};

    assign l2_be_o    = second ? be_span[7:4] : be_span[3:0];
    assign l2_wdata_o = second ? data_span[63:32] : data_span[31:0];

    //////////////////////////////////////////////////////////////////////
    // address
    //////////////////////////////////////////////////////////////////////

    assign word_addr = second ? addr_i[ADDR_W-1:2] + 1'b1 : addr_i[ADDR_W-1:2];

    always_comb
    begin
        l2_addr_o = {{(32-ADDR_W){1'b0}}, word_addr, 2'b00};
        case (dest_i)
            2'd1:    l2_addr_o[31:20] = DEST1_PREFIX;
            2'd2:    l2_addr_o[31:24] = DEST2_PREFIX;
            default: l2_addr_o[31:24] = DEST0_PREFIX;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // write FSM
    //////////////////////////////////////////////////////////////////////

    assign l2_req_o = not_empty_i;
    assign pop_o    = not_empty_i && l2_gnt_i && (second || !is_split);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            WR_IDLE:
                if (not_empty_i && l2_gnt_i && is_split)
                    state_d = WR_SECOND;  // aligned part accepted, head stays
            WR_SECOND:
                if (l2_gnt_i)
                    state_d = WR_IDLE;
            default:
                state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= WR_IDLE;
        else
            state_q <= state_d;
    end

    // largest byte count the size code allows, code 3 counts as a byte
    always_comb
    begin
        case (dsize_i)
            2'd1:    size_nbytes = 2'd1;
            2'd2:    size_nbytes = 2'd3;
            default: size_nbytes = 2'd0;
        endcase
    end

    // the channel may trim a beat but never widens it
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        not_empty_i |-> nbytes_i <= size_nbytes);

    // a waiting request keeps its head beat until the grant
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o && !l2_gnt_i |=>
            l2_req_o && $stable(l2_addr_o) && $stable(l2_be_o) && $stable(l2_wdata_o));

endmodule

// ==== hdl/udma_rx_top.sv ====
// receive side of the micro-DMA with input stage, beat buffer and L2 write port
`timescale 1ns/1ps

module udma_rx_top #(
    parameter int N_CH       = rx_pkg::N_CH,
    parameter int FIFO_DEPTH = rx_pkg::FIFO_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic           [N_CH-1:0]    ch_valid_i,
    input  rx_pkg::data_t  [N_CH-1:0]    ch_data_i,
    input  rx_pkg::dsize_t [N_CH-1:0]    ch_dsize_i,
    input  rx_pkg::dest_t  [N_CH-1:0]    ch_dest_i,
    output logic           [N_CH-1:0]    ch_ready_o,
    input  rx_pkg::addr_t  [N_CH-1:0]    cfg_startaddr_i,
    input  rx_pkg::len_t   [N_CH-1:0]    cfg_len_i,
    input  logic           [N_CH-1:0]    cfg_en_i,
    output logic           [N_CH-1:0]    ch_en_o,
    output logic           [N_CH-1:0]    ch_event_o,
    output logic                         l2_req_o,
    input  logic                         l2_gnt_i,
    output logic           [31:0]        l2_addr_o,
    output rx_pkg::be_t                  l2_be_o,
    output rx_pkg::data_t                l2_wdata_o
);
    import rx_pkg::*;

    logic    push;
    logic    pop;
    logic    space;
    logic    not_empty;
    data_t   push_data;
    addr_t   push_addr;
    dsize_t  push_dsize;
    nbytes_t push_nbytes;
    dest_t   push_dest;
    data_t   head_data;
    addr_t   head_addr;
    dsize_t  head_dsize;
    nbytes_t head_nbytes;
    dest_t   head_dest;

    rx_input_stage #(
        .N_CH ( N_CH )
    ) u_input_stage (
        .clk_i           ( clk_i           ),
        .rstn_i          ( rstn_i          ),
        .ch_valid_i      ( ch_valid_i      ),
        .ch_data_i       ( ch_data_i       ),
        .ch_dsize_i      ( ch_dsize_i      ),
        .ch_dest_i       ( ch_dest_i       ),
        .ch_ready_o      ( ch_ready_o      ),
        .cfg_startaddr_i ( cfg_startaddr_i ),
        .cfg_len_i       ( cfg_len_i       ),
        .cfg_en_i        ( cfg_en_i        ),
        .ch_en_o         ( ch_en_o         ),
        .ch_event_o      ( ch_event_o      ),
        .space_i         ( space           ),
        .push_o          ( push            ),
        .beat_data_o     ( push_data       ),
        .beat_addr_o     ( push_addr       ),
        .beat_dsize_o    ( push_dsize      ),
        .beat_nbytes_o   ( push_nbytes     ),
        .beat_dest_o     ( push_dest       )
    );

    rx_beat_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_beat_fifo (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .push_i      ( push        ),
        .data_i      ( push_data   ),
        .addr_i      ( push_addr   ),
        .dsize_i     ( push_dsize  ),
        .nbytes_i    ( push_nbytes ),
        .dest_i      ( push_dest   ),
        .space_o     ( space       ),
        .not_empty_o ( not_empty   ),
        .data_o      ( head_data   ),
        .addr_o      ( head_addr   ),
        .dsize_o     ( head_dsize  ),
        .nbytes_o    ( head_nbytes ),
        .dest_o      ( head_dest   ),
        .pop_i       ( pop         )
    );

    l2_write_port u_l2_write_port (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .not_empty_i ( not_empty   ),
        .data_i      ( head_data   ),
        .addr_i      ( head_addr   ),
        .dsize_i     ( head_dsize  ),
        .nbytes_i    ( head_nbytes ),
        .dest_i      ( head_dest   ),
        .pop_o       ( pop         ),
        .l2_req_o    ( l2_req_o    ),
        .l2_gnt_i    ( l2_gnt_i    ),
        .l2_addr_o   ( l2_addr_o   ),
        .l2_be_o     ( l2_be_o     ),
        .l2_wdata_o  ( l2_wdata_o  )
    );

endmodule

// ==== verification/tb_l2_model.svh ====
// model functions for beat byte count, prefixed word address, L2 lanes and lane data
`ifndef TB_L2_MODEL_SVH
`define TB_L2_MODEL_SVH

// bytes carried by one beat, limited by what is left of the transfer
function automatic int beat_bytes(input dsize_t dsize, input int remain);
    int size;
    case (dsize)
        2'd1:    size = 2;
        2'd2:    size = 4;
        default: size = 1;
    endcase
    return (remain < size) ? remain : size;
endfunction

// word address of a byte with the destination prefix on top
function automatic logic [31:0] prefixed_addr(input dest_t dest, input addr_t byte_addr);
    logic [31:0] a;
    a      = 32'(byte_addr);
    a[1:0] = 2'b00;
    case (dest)
        2'd1:    a[31:20] = DEST1_PREFIX;
        2'd2:    a[31:24] = DEST2_PREFIX;
        default: a[31:24] = DEST0_PREFIX;   // codes 0 and 3
    endcase
    return a;
endfunction

function automatic bit crosses_word(input int offset, input int nbytes);
    return (offset + nbytes) > 4;
endfunction

// byte i of the beat lands on lane offset+i, lanes 4 and up belong to the next word
function automatic be_t word_lanes(input int offset, input int nbytes, input bit upper);
    be_t be;
    int  lane;
    be = '0;
    for (int i = 0; i < nbytes; i++)
    begin
        lane = offset + i - (upper ? 4 : 0);
        if (lane >= 0 && lane < 4)
            be[lane] = 1'b1;
    end
    return be;
endfunction

function automatic data_t word_data(input data_t data, input int offset, input int nbytes,
                                    input bit upper);
    data_t d;
    int    lane;
    d = '0;
    for (int i = 0; i < nbytes; i++)
    begin
        lane = offset + i - (upper ? 4 : 0);
        if (lane >= 0 && lane < 4)
            d[8*lane +: 8] = data[8*i +: 8];
    end
    return d;
endfunction

// only lanes with a byte enable carry data that matters
function automatic data_t lane_bits(input be_t be);
    data_t m;
    for (int b = 0; b < 4; b++)
        m[8*b +: 8] = {8{be[b]}};
    return m;
endfunction

`endif

// ==== verification/tb_udma_rx.sv ====
// testbench for udma_rx_top with LFSR traffic, random grants, L2 write model and watchdog
`timescale 1ns/1ps

module tb_udma_rx;
    import rx_pkg::*;

    `include "tb_l2_model.svh"

    localparam int N_CH        = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int CLK_PERIOD  = 100;
    localparam int ROUNDS      = 8;
    localparam int MAX_LEN     = 64;
    localparam int BEAT_CYCLES = 48;   // worst case per beat with grant stalls and arbitration
    localparam longint TIMEOUT_NS =
        longint'(ROUNDS) * N_CH * MAX_LEN * BEAT_CYCLES * CLK_PERIOD + 1000 * CLK_PERIOD;

    logic                  clk_i;
    logic                  rstn_i;
    logic   [N_CH-1:0]     ch_valid_i;
    data_t  [N_CH-1:0]     ch_data_i;
    dsize_t [N_CH-1:0]     ch_dsize_i;
    dest_t  [N_CH-1:0]     ch_dest_i;
    logic   [N_CH-1:0]     ch_ready_o;
    addr_t  [N_CH-1:0]     cfg_startaddr_i;
    len_t   [N_CH-1:0]     cfg_len_i;
    logic   [N_CH-1:0]     cfg_en_i;
    logic   [N_CH-1:0]     ch_en_o;
    logic   [N_CH-1:0]     ch_event_o;
    logic                  l2_req_o;
    logic                  l2_gnt_i;
    logic   [31:0]         l2_addr_o;
    be_t                   l2_be_o;
    data_t                 l2_wdata_o;

    logic [31:0]     lfsr_q;
    logic [3:0]      gnt_level;      // grant chance in eighths
    int              errors;
    int              writes;
    int              beats;
    logic [67:0]     exp_q [N_CH][$];   // expected writes, {addr, be, data}
    addr_t           mdl_addr [N_CH];
    int              mdl_remain [N_CH];
    int              event_cnt [N_CH];
    logic [N_CH-1:0] exp_en;
    logic [N_CH-1:0] exp_event;
    logic            wait_prev;
    logic [31:0]     prev_addr;
    be_t             prev_be;
    data_t           prev_data;

    udma_rx_top #(
        .N_CH       ( N_CH       ),
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) DUT (
        .clk_i           ( clk_i           ),
        .rstn_i          ( rstn_i          ),
        .ch_valid_i      ( ch_valid_i      ),
        .ch_data_i       ( ch_data_i       ),
        .ch_dsize_i      ( ch_dsize_i      ),
        .ch_dest_i       ( ch_dest_i       ),
        .ch_ready_o      ( ch_ready_o      ),
        .cfg_startaddr_i ( cfg_startaddr_i ),
        .cfg_len_i       ( cfg_len_i       ),
        .cfg_en_i        ( cfg_en_i        ),
        .ch_en_o         ( ch_en_o         ),
        .ch_event_o      ( ch_event_o      ),
        .l2_req_o        ( l2_req_o        ),
        .l2_gnt_i        ( l2_gnt_i        ),
        .l2_addr_o       ( l2_addr_o       ),
        .l2_be_o         ( l2_be_o         ),
        .l2_wdata_o      ( l2_wdata_o      )
    );

    //////////////////////////////////////////////////////////////////////
    // random numbers and checks
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic print_counts();
        $display("errors %0d, L2 writes checked %0d, beats accepted %0d", errors, writes, beats);
    endtask

    function automatic bit work_pending();
        bit busy;
        busy = |exp_en;
        for (int c = 0; c < N_CH; c++)
            if (exp_q[c].size() != 0)
                busy = 1'b1;
        return busy;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_traffic();
        logic [31:0] r;
        for (int c = 0; c < N_CH; c++)
        begin
            take_bits(1, r);
            ch_valid_i[c] <= r[0];
            take_bits(32, r);
            ch_data_i[c] <= r;
            take_bits(2, r);
            ch_dsize_i[c] <= (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
            take_bits(2, r);
            ch_dest_i[c] <= r[1:0];
        end
        take_bits(3, r);
        l2_gnt_i <= ({1'b0, r[2:0]} < gnt_level);
    endtask

    // each channel works in its own 4 KB region
    task automatic configure_round();
        logic [31:0] offset;
        logic [31:0] len;
        for (int c = 0; c < N_CH; c++)
        begin
            take_bits(8, offset);
            take_bits(6, len);
            cfg_startaddr_i[c] <= addr_t'((c << 12) + int'(offset));
            cfg_len_i[c]       <= len_t'(len) + len_t'(1);
        end
        cfg_en_i <= '1;
    endtask

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial
    begin
        lfsr_q          = 32'hc7c;
        errors          = 0;
        writes          = 0;
        beats           = 0;
        gnt_level       = 4'd8;
        rstn_i          = 1'b0;
        ch_valid_i      = '0;
        ch_data_i       = '0;
        ch_dsize_i      = '0;
        ch_dest_i       = '0;
        cfg_startaddr_i = '0;
        cfg_len_i       = '0;
        cfg_en_i        = '0;
        l2_gnt_i        = 1'b0;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int round = 0; round < ROUNDS; round++)
        begin
            gnt_level = 4'(2 + 2 * (round % 4));   // from 25 % up to always granted
            @(posedge clk_i);
            configure_round();
            drive_traffic();
            @(posedge clk_i);
            cfg_en_i <= '0;
            drive_traffic();
            while (work_pending())
            begin
                @(posedge clk_i);
                drive_traffic();
            end
        end
        repeat (2) @(posedge clk_i);
        for (int c = 0; c < N_CH; c++)
            check_value("ch_event_o count", 32'(event_cnt[c]), 32'(ROUNDS));
        print_counts();
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: transfers were still pending at %0t", $time);
        print_counts();
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // monitor and model, sampled mid-cycle where everything is settled
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i)
    begin : monitor
        int              c;
        int              n;
        int              offset;
        logic [67:0]     entry;
        logic [N_CH-1:0] next_event;
        if (!rstn_i)
        begin
            exp_en    = '0;
            exp_event = '0;
            wait_prev = 1'b0;
            for (int k = 0; k < N_CH; k++)
                event_cnt[k] = 0;
        end
        else
        begin
            check_value("ch_en_o", 32'(ch_en_o), 32'(exp_en));
            check_value("ch_event_o", 32'(ch_event_o), 32'(exp_event));
            check_value("ch_ready_o", 32'(ch_ready_o & ~exp_en), 32'h0);  // disabled ones
            for (int k = 0; k < N_CH; k++)
                if (ch_event_o[k])
                    event_cnt[k]++;

            if (wait_prev)
            begin
                check_value("l2_req_o", 32'(l2_req_o), 32'h1);
                check_value("l2_addr_o", l2_addr_o, prev_addr);
                check_value("l2_be_o", 32'(l2_be_o), 32'(prev_be));
                check_value("l2_wdata_o", l2_wdata_o, prev_data);
            end
            wait_prev = l2_req_o && !l2_gnt_i;
            prev_addr = l2_addr_o;
            prev_be   = l2_be_o;
            prev_data = l2_wdata_o;

            // the write completes on the coming edge
            if (l2_req_o && l2_gnt_i)
            begin
                c = int'(l2_addr_o[15:12]);
                if (c >= N_CH || exp_q[c].size() == 0)
                begin
                    errors++;
                    $display("unexpected L2 write to %h at %0t, nothing was pending for it",
                             l2_addr_o, $time);
                end
                else
                begin
                    entry = exp_q[c].pop_front();
                    writes++;
                    check_value("l2_addr_o", l2_addr_o, entry[67:36]);
                    check_value("l2_be_o", 32'(l2_be_o), 32'(entry[35:32]));
                    check_value("l2_wdata_o", l2_wdata_o & lane_bits(entry[35:32]), entry[31:0]);
                end
            end

            next_event = '0;
            for (int k = 0; k < N_CH; k++)
            begin
                if (cfg_en_i[k])
                begin
                    mdl_addr[k]   = cfg_startaddr_i[k];
                    mdl_remain[k] = int'(cfg_len_i[k]);
                    exp_en[k]     = (cfg_len_i[k] != '0);
                end
                else if (ch_valid_i[k] && ch_ready_o[k])
                begin
                    n      = beat_bytes(ch_dsize_i[k], mdl_remain[k]);
                    offset = int'(mdl_addr[k][1:0]);
                    exp_q[k].push_back({prefixed_addr(ch_dest_i[k], mdl_addr[k]),
                                        word_lanes(offset, n, 1'b0),
                                        word_data(ch_data_i[k], offset, n, 1'b0)});
                    if (crosses_word(offset, n))
                        exp_q[k].push_back({prefixed_addr(ch_dest_i[k], mdl_addr[k] + addr_t'(4)),
                                            word_lanes(offset, n, 1'b1),
                                            word_data(ch_data_i[k], offset, n, 1'b1)});
                    mdl_addr[k]   = mdl_addr[k] + addr_t'(n);
                    mdl_remain[k] = mdl_remain[k] - n;
                    beats++;
                    if (mdl_remain[k] <= 0)
                    begin
                        exp_en[k]     = 1'b0;
                        next_event[k] = 1'b1;
                    end
                end
            end
            exp_event = next_event;
        end
    end

endmodule

// ==== sim.f ====
+incdir+verification
hdl/rx_pkg.sv
hdl/rx_channel_addr.sv
hdl/rx_input_stage.sv
hdl/rx_beat_fifo.sv
hdl/l2_write_port.sv
hdl/udma_rx_top.sv
verification/tb_udma_rx.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_udma_rx
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
